// File: common/axi_write_pkg.sv
package axi_write_pkg;

  // bus geometry
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BEAT_BYTES = DATA_W / 8;
  localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);

  // burst limits
  localparam int MAX_BURST_LEN  = 16;
  localparam int BOUNDARY_BYTES = 4096;
  localparam int LEN_W          = 8;

  // client beat count, beats minus one
  localparam int REQ_LEN_W = 16;

  // queue depths
  localparam int CMD_FIFO_DEPTH = 4;
  localparam int LEN_FIFO_DEPTH = 4;

  // write responses still owed by the slave
  localparam int MAX_OUTSTANDING = 8;
  localparam int OUTST_W         = $clog2(MAX_OUTSTANDING + 1);

  // one client write request
  typedef struct packed {
    logic [ADDR_W-1:0]    addr;
    logic [REQ_LEN_W-1:0] len;
  } write_req_t;

  // one AXI burst, len is awlen
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } aw_cmd_t;

endpackage

// File: design/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             enq_valid,
  input  logic [WIDTH-1:0] enq_data,
  output logic             enq_ready,
  output logic             deq_valid,
  output logic [WIDTH-1:0] deq_data,
  input  logic             deq_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             enq_fire;
  logic             deq_fire;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1))
      return '0;
    return p + PTR_W'(1);
  endfunction

  assign enq_ready = (count != CNT_W'(DEPTH));
  assign deq_valid = (count != '0);
  // head word is visible as soon as it is written
  assign deq_data  = mem[rd_ptr];

  assign enq_fire = enq_valid & enq_ready;
  assign deq_fire = deq_valid & deq_ready;

  always_ff @(posedge clk) begin
    if (enq_fire)
      mem[wr_ptr] <= enq_data;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire)
        wr_ptr <= next_ptr(wr_ptr);
      if (deq_fire)
        rd_ptr <= next_ptr(rd_ptr);
      case ({enq_fire, deq_fire})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// File: burst_split/burst_split_fsm.sv
`timescale 1ns/1ps

module burst_split_fsm (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    req_valid,
  input  axi_write_pkg::write_req_t req,
  output logic                    req_ready,
  output logic                    cmd_valid,
  output axi_write_pkg::aw_cmd_t  cmd,
  input  logic                    cmd_ready,
  output logic                    busy
);

  import axi_write_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    CHUNK,
    CHECK,
    EMIT_LO,
    EMIT_HI
  } state_t;

  state_t state;
  state_t state_next;

  // remaining work of the current request
  logic [ADDR_W-1:0]  rem_addr;
  logic [REQ_LEN_W:0] rem_beats;

  // current chunk, and its part below the 4 KB line
  logic [LEN_W:0] chunk_beats;
  logic [LEN_W:0] lo_beats;

  logic [ADDR_W-1:0] line_base;
  logic [ADDR_W-1:0] bytes_to_line;
  logic [ADDR_W-1:0] chunk_bytes;
  logic              crosses;
  logic              req_fire;
  logic              cmd_fire;

  assign req_fire = req_valid & req_ready;
  assign cmd_fire = cmd_valid & cmd_ready;

  assign line_base     = rem_addr & ~ADDR_W'(BOUNDARY_BYTES - 1);
  assign bytes_to_line = line_base + ADDR_W'(BOUNDARY_BYTES) - rem_addr;
  assign chunk_bytes   = ADDR_W'(chunk_beats) << BEAT_SHIFT;
  assign crosses       = (chunk_bytes > bytes_to_line);

  assign req_ready = (state == IDLE);
  assign busy      = (state != IDLE);
  assign cmd_valid = (state == EMIT_LO) || (state == EMIT_HI);

  always_comb begin
    cmd.addr = rem_addr;
    if (state == EMIT_LO)
      cmd.len = LEN_W'(lo_beats - (LEN_W + 1)'(1));
    else
      cmd.len = LEN_W'(chunk_beats - (LEN_W + 1)'(1));
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_fire)
          state_next = CHUNK;
      end
      CHUNK: begin
        state_next = CHECK;
      end
      CHECK: begin
        if (crosses)
          state_next = EMIT_LO;
        else
          state_next = EMIT_HI;
      end
      EMIT_LO: begin
        if (cmd_fire)
          state_next = EMIT_HI;
      end
      EMIT_HI: begin
        // last chunk of the request
        if (cmd_fire) begin
          if (rem_beats == (REQ_LEN_W + 1)'(chunk_beats))
            state_next = IDLE;
          else
            state_next = CHUNK;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)
      state <= IDLE;
    else
      state <= state_next;
  end

  always_ff @(posedge clk) begin
    case (state)
      IDLE: begin
        if (req_fire) begin
          rem_addr  <= req.addr;
          rem_beats <= {1'b0, req.len} + (REQ_LEN_W + 1)'(1);
        end
      end
      CHUNK: begin
        if (rem_beats > (REQ_LEN_W + 1)'(MAX_BURST_LEN))
          chunk_beats <= (LEN_W + 1)'(MAX_BURST_LEN);
        else
          chunk_beats <= (LEN_W + 1)'(rem_beats);
      end
      CHECK: begin
        // only meaningful when the chunk crosses, so it is below chunk_beats
        lo_beats <= (LEN_W + 1)'(bytes_to_line >> BEAT_SHIFT);
      end
      EMIT_LO: begin
        if (cmd_fire) begin
          rem_addr    <= rem_addr + (ADDR_W'(lo_beats) << BEAT_SHIFT);
          rem_beats   <= rem_beats - (REQ_LEN_W + 1)'(lo_beats);
          chunk_beats <= chunk_beats - lo_beats;
        end
      end
      EMIT_HI: begin
        if (cmd_fire) begin
          rem_addr  <= rem_addr + chunk_bytes;
          rem_beats <= rem_beats - (REQ_LEN_W + 1)'(chunk_beats);
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// File: design/aw_issue.sv
`timescale 1ns/1ps

module aw_issue (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              cmd_valid,
  input  axi_write_pkg::aw_cmd_t            cmd,
  output logic                              cmd_ready,
  input  logic                              split_busy,
  output logic                              m_awvalid,
  input  logic                              m_awready,
  output logic [axi_write_pkg::ADDR_W-1:0]  m_awaddr,
  output logic [axi_write_pkg::LEN_W-1:0]   m_awlen,
  output logic                              len_valid,
  output logic [axi_write_pkg::LEN_W-1:0]   len,
  input  logic                              len_ready,
  input  logic                              m_bvalid,
  output logic                              m_bready,
  output logic                              write_idle
);

  import axi_write_pkg::*;

  logic [OUTST_W-1:0] outst_cnt;
  logic               aw_allowed;
  logic               aw_fire;
  logic               b_fire;

  // neither condition can change while awvalid waits, only an AW transfer moves them
  assign aw_allowed = len_ready && (outst_cnt != OUTST_W'(MAX_OUTSTANDING));

  assign m_awvalid = cmd_valid & aw_allowed;
  assign m_awaddr  = cmd.addr;
  assign m_awlen   = cmd.len;
  assign cmd_ready = m_awready & aw_allowed;

  assign aw_fire = m_awvalid & m_awready;

  // hand the beat count to the W side on the AW transfer itself
  assign len_valid = aw_fire;
  assign len       = cmd.len;

  assign m_bready = (outst_cnt != '0);
  assign b_fire   = m_bvalid & m_bready;

  assign write_idle = !split_busy && !cmd_valid && (outst_cnt == '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outst_cnt <= '0;
    end else begin
      case ({aw_fire, b_fire})
        2'b10:   outst_cnt <= outst_cnt + OUTST_W'(1);
        2'b01:   outst_cnt <= outst_cnt - OUTST_W'(1);
        default: outst_cnt <= outst_cnt;
      endcase
    end
  end

endmodule

// File: design/wdata_beat_counter.sv
`timescale 1ns/1ps

module wdata_beat_counter (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             len_valid,
  input  logic [axi_write_pkg::LEN_W-1:0]  len,
  output logic                             len_ready,
  input  logic [axi_write_pkg::DATA_W-1:0] wdata_in,
  input  logic                             wdata_valid,
  output logic                             wdata_ready,
  output logic                             m_wvalid,
  input  logic                             m_wready,
  output logic [axi_write_pkg::DATA_W-1:0] m_wdata,
  output logic                             m_wlast
);

  import axi_write_pkg::*;

  logic             running;
  logic [LEN_W-1:0] burst_len;
  logic [LEN_W-1:0] beat_cnt;
  logic             len_fire;
  logic             w_fire;

  assign len_ready = ~running;
  assign len_fire  = len_valid & len_ready;

  // data path is a straight pass while a burst runs
  assign m_wdata     = wdata_in;
  assign m_wvalid    = running & wdata_valid;
  assign wdata_ready = running & m_wready;
  assign m_wlast     = running && (beat_cnt == burst_len);

  assign w_fire = m_wvalid & m_wready;

  always_ff @(posedge clk) begin
    if (len_fire)
      burst_len <= len;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running  <= 1'b0;
      beat_cnt <= '0;
    end else begin
      if (len_fire)
        running <= 1'b1;
      if (w_fire) begin
        if (m_wlast) begin
          running  <= 1'b0;
          beat_cnt <= '0;
        end else begin
          beat_cnt <= beat_cnt + LEN_W'(1);
        end
      end
    end
  end

endmodule

// File: design/axi_write_master.sv
`timescale 1ns/1ps

module axi_write_master (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              req_valid,
  input  axi_write_pkg::write_req_t         req,
  output logic                              req_ready,
  input  logic [axi_write_pkg::DATA_W-1:0]  wdata_in,
  input  logic                              wdata_valid,
  output logic                              wdata_ready,
  output logic                              m_awvalid,
  input  logic                              m_awready,
  output logic [axi_write_pkg::ADDR_W-1:0]  m_awaddr,
  output logic [axi_write_pkg::LEN_W-1:0]   m_awlen,
  output logic                              m_wvalid,
  input  logic                              m_wready,
  output logic [axi_write_pkg::DATA_W-1:0]  m_wdata,
  output logic                              m_wlast,
  input  logic                              m_bvalid,
  output logic                              m_bready,
  output logic                              write_idle
);

  import axi_write_pkg::*;

  // splitter to command queue
  logic    split_cmd_valid;
  aw_cmd_t split_cmd;
  logic    split_cmd_ready;
  logic    split_busy;

  // command queue to AW
  logic    cmd_q_valid;
  aw_cmd_t cmd_q;
  logic    cmd_q_ready;

  // burst lengths from AW side to W side
  logic             len_push_valid;
  logic [LEN_W-1:0] len_push;
  logic             len_push_ready;
  logic             len_pop_valid;
  logic [LEN_W-1:0] len_pop;
  logic             len_pop_ready;

  burst_split_fsm u_split (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .cmd_valid (split_cmd_valid),
    .cmd       (split_cmd),
    .cmd_ready (split_cmd_ready),
    .busy      (split_busy)
  );

  sync_fifo #(
    .WIDTH ($bits(aw_cmd_t)),
    .DEPTH (CMD_FIFO_DEPTH)
  ) cmd_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .enq_valid (split_cmd_valid),
    .enq_data  (split_cmd),
    .enq_ready (split_cmd_ready),
    .deq_valid (cmd_q_valid),
    .deq_data  (cmd_q),
    .deq_ready (cmd_q_ready)
  );

  aw_issue u_aw_issue (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_valid  (cmd_q_valid),
    .cmd        (cmd_q),
    .cmd_ready  (cmd_q_ready),
    .split_busy (split_busy),
    .m_awvalid  (m_awvalid),
    .m_awready  (m_awready),
    .m_awaddr   (m_awaddr),
    .m_awlen    (m_awlen),
    .len_valid  (len_push_valid),
    .len        (len_push),
    .len_ready  (len_push_ready),
    .m_bvalid   (m_bvalid),
    .m_bready   (m_bready),
    .write_idle (write_idle)
  );

  sync_fifo #(
    .WIDTH (LEN_W),
    .DEPTH (LEN_FIFO_DEPTH)
  ) len_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .enq_valid (len_push_valid),
    .enq_data  (len_push),
    .enq_ready (len_push_ready),
    .deq_valid (len_pop_valid),
    .deq_data  (len_pop),
    .deq_ready (len_pop_ready)
  );

  wdata_beat_counter u_wbeat (
    .clk         (clk),
    .arst_n      (arst_n),
    .len_valid   (len_pop_valid),
    .len         (len_pop),
    .len_ready   (len_pop_ready),
    .wdata_in    (wdata_in),
    .wdata_valid (wdata_valid),
    .wdata_ready (wdata_ready),
    .m_wvalid    (m_wvalid),
    .m_wready    (m_wready),
    .m_wdata     (m_wdata),
    .m_wlast     (m_wlast)
  );

endmodule

// File: tb/axi_write_properties.sv
`timescale 1ns/1ps

module axi_write_properties (
  input logic                             clk,
  input logic                             arst_n,
  input logic                             m_awvalid,
  input logic                             m_awready,
  input logic [axi_write_pkg::ADDR_W-1:0] m_awaddr,
  input logic [axi_write_pkg::LEN_W-1:0]  m_awlen,
  input logic                             m_bvalid,
  input logic                             m_bready
);

  import axi_write_pkg::*;

  logic [OUTST_W-1:0] outstanding;
  logic [ADDR_W:0]    burst_end;

  // byte after the burst, as an offset into its 4 KB line
  assign burst_end = (ADDR_W + 1)'(m_awaddr & ADDR_W'(BOUNDARY_BYTES - 1))
                   + (((ADDR_W + 1)'(m_awlen) + (ADDR_W + 1)'(1)) << BEAT_SHIFT);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= '0;
    end else begin
      case ({m_awvalid & m_awready, m_bvalid & m_bready})
        2'b10:   outstanding <= outstanding + OUTST_W'(1);
        2'b01:   outstanding <= outstanding - OUTST_W'(1);
        default: outstanding <= outstanding;
      endcase
    end
  end

  no_line_cross: assert property (@(posedge clk) disable iff (!arst_n)
    m_awvalid |-> (burst_end <= (ADDR_W + 1)'(BOUNDARY_BYTES)))
    else $error("burst at 0x%0h crosses a 4 KB line", m_awaddr);

  awlen_limit: assert property (@(posedge clk) disable iff (!arst_n)
    m_awvalid |-> (m_awlen <= LEN_W'(MAX_BURST_LEN - 1)))
    else $error("awlen 0x%0h is above the burst limit", m_awlen);

  aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (m_awvalid && !m_awready) |=> (m_awvalid && $stable(m_awaddr) && $stable(m_awlen)))
    else $error("AW changed while waiting for awready");

  bready_needs_burst: assert property (@(posedge clk) disable iff (!arst_n)
    m_bready |-> (outstanding != '0))
    else $error("bready high with no burst outstanding");

endmodule

bind axi_write_master axi_write_properties u_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .m_awvalid (m_awvalid),
  .m_awready (m_awready),
  .m_awaddr  (m_awaddr),
  .m_awlen   (m_awlen),
  .m_bvalid  (m_bvalid),
  .m_bready  (m_bready)
);

// File: tb/tb_axi_write_master.sv
`timescale 1ns/1ps

module tb_axi_write_master;

  import axi_write_pkg::*;

  localparam int NUM_FIXED  = 3;
  localparam int NUM_REQ    = NUM_FIXED + 6;
  localparam logic [DATA_W-1:0] DATA_BASE = 32'hA5A5_0000;

  logic              clk;
  logic              arst_n;
  logic              req_valid;
  write_req_t        req;
  logic              req_ready;
  logic [DATA_W-1:0] wdata_in;
  logic              wdata_valid;
  logic              wdata_ready;
  logic              m_awvalid;
  logic              m_awready;
  logic [ADDR_W-1:0] m_awaddr;
  logic [LEN_W-1:0]  m_awlen;
  logic              m_wvalid;
  logic              m_wready;
  logic [DATA_W-1:0] m_wdata;
  logic              m_wlast;
  logic              m_bvalid;
  logic              m_bready;
  logic              write_idle;

  write_req_t        req_list [NUM_REQ];
  // bursts the splitting rule predicts, oldest first
  logic [ADDR_W-1:0] exp_addr_q [$];
  logic [LEN_W-1:0]  exp_len_q [$];
  // awlen of bursts open on W and the cycle at which each B is due
  logic [LEN_W-1:0]  w_len_q [$];
  int unsigned       b_due_q [$];
  int unsigned       cycle;
  int unsigned       timeout_limit;
  int unsigned       total_beats;
  int unsigned       total_bursts;
  int unsigned       aw_seen;
  int unsigned       beats_seen;
  int unsigned       client_beats;
  int unsigned       beat_in_burst;

  axi_write_master DUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .wdata_in    (wdata_in),
    .wdata_valid (wdata_valid),
    .wdata_ready (wdata_ready),
    .m_awvalid   (m_awvalid),
    .m_awready   (m_awready),
    .m_awaddr    (m_awaddr),
    .m_awlen     (m_awlen),
    .m_wvalid    (m_wvalid),
    .m_wready    (m_wready),
    .m_wdata     (m_wdata),
    .m_wlast     (m_wlast),
    .m_bvalid    (m_bvalid),
    .m_bready    (m_bready),
    .write_idle  (write_idle)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual)
    else abort_run($sformatf("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual));
  endtask

  // max-length chunks that are cut once more at a 4 KB line
  task automatic add_expected_bursts(input write_req_t r);
    logic [ADDR_W-1:0] addr;
    int unsigned       remaining;
    int unsigned       chunk;
    int unsigned       room;
    addr      = r.addr;
    remaining = 32'(r.len) + 1;
    while (remaining > 0) begin
      chunk = (remaining > MAX_BURST_LEN) ? MAX_BURST_LEN : remaining;
      room  = (BOUNDARY_BYTES - 32'(addr % ADDR_W'(BOUNDARY_BYTES))) / BEAT_BYTES;
      if (chunk > room) begin
        exp_addr_q.push_back(addr);
        exp_len_q.push_back(LEN_W'(room - 1));
        addr         = addr + ADDR_W'(room * BEAT_BYTES);
        remaining    = remaining - room;
        chunk        = chunk - room;
        total_bursts = total_bursts + 1;
      end
      exp_addr_q.push_back(addr);
      exp_len_q.push_back(LEN_W'(chunk - 1));
      addr         = addr + ADDR_W'(chunk * BEAT_BYTES);
      remaining    = remaining - chunk;
      total_bursts = total_bursts + 1;
    end
  endtask

  task automatic send_request(input write_req_t r);
    add_expected_bursts(r);
    @(posedge clk);
    #1;
    req_valid = 1'b1;
    req       = r;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  // slave readiness, client data and B responses
  always @(posedge clk) begin
    #1;
    m_awready   = ($urandom_range(0, 3) != 0);
    m_wready    = ($urandom_range(0, 3) != 0);
    wdata_valid = arst_n;
    wdata_in    = DATA_BASE + client_beats;
    m_bvalid    = (b_due_q.size() != 0) && (b_due_q[0] <= cycle);
  end

  // the client moves to its next word only on its own handshake
  always @(negedge clk) begin
    if (arst_n && wdata_valid && wdata_ready)
      client_beats = client_beats + 1;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_limit)
      abort_run($sformatf("timeout after %0d cycles, the write never completed", cycle));
  end

  always @(negedge clk) begin
    if (arst_n && m_awvalid && m_awready) begin
      if (exp_addr_q.size() == 0) begin
        abort_run("an AW burst appeared that no request accounts for");
      end else begin
        check_value("m_awaddr", exp_addr_q[0], m_awaddr);
        check_value("m_awlen", 32'(exp_len_q[0]), 32'(m_awlen));
        void'(exp_addr_q.pop_front());
        void'(exp_len_q.pop_front());
        w_len_q.push_back(m_awlen);
        aw_seen = aw_seen + 1;
      end
    end
  end

  always @(negedge clk) begin
    if (arst_n && m_wvalid && m_wready) begin
      if (w_len_q.size() == 0) begin
        abort_run("a W beat arrived while no burst was open on AW");
      end else begin
        check_value("m_wdata", DATA_BASE + beats_seen, m_wdata);
        check_value("m_wlast", 32'(beat_in_burst == 32'(w_len_q[0])), 32'(m_wlast));
        beats_seen = beats_seen + 1;
        if (m_wlast) begin
          void'(w_len_q.pop_front());
          beat_in_burst = 0;
          b_due_q.push_back(cycle + $urandom_range(1, 6));
        end else begin
          beat_in_burst = beat_in_burst + 1;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (arst_n && m_bvalid && m_bready)
      void'(b_due_q.pop_front());
  end

  initial begin
    void'($urandom(72409));
    clk         = 1'b0;
    arst_n      = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    wdata_in    = DATA_BASE;
    wdata_valid = 1'b0;
    m_awready   = 1'b0;
    m_wready    = 1'b0;
    m_bvalid    = 1'b0;
    cycle       = 0;
    aw_seen     = 0;
    beats_seen  = 0;
    client_beats  = 0;
    beat_in_burst = 0;
    total_bursts  = 0;
    // single burst, 16 + 16 + 8, and a split 8 bytes below a 4 KB line
    req_list[0] = '{addr: 32'h0000_0100, len: 16'd7};
    req_list[1] = '{addr: 32'h0000_2000, len: 16'd39};
    req_list[2] = '{addr: 32'h0000_3FF8, len: 16'd3};
    // random starts near the top of a line so that splits are common
    for (int i = NUM_FIXED; i < NUM_REQ; i++) begin
      req_list[i].addr = ADDR_W'(($urandom_range(0, 63) << 12) |
                                 ($urandom_range(32'hE00, 32'hFFF) & 32'hFFC));
      req_list[i].len  = REQ_LEN_W'($urandom_range(0, 63));
    end
    total_beats = 0;
    foreach (req_list[i])
      total_beats = total_beats + 32'(req_list[i].len) + 1;
    timeout_limit = 20 * total_beats + 2000;

    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_value("req_ready", 32'd1, 32'(req_ready));
    check_value("write_idle", 32'd1, 32'(write_idle));
    check_value("m_awvalid", 32'd0, 32'(m_awvalid));
    check_value("m_wvalid", 32'd0, 32'(m_wvalid));
    check_value("m_wlast", 32'd0, 32'(m_wlast));
    check_value("m_bready", 32'd0, 32'(m_bready));
    check_value("wdata_ready", 32'd0, 32'(wdata_ready));

    foreach (req_list[i])
      send_request(req_list[i]);

    do @(negedge clk);
    while (!(write_idle && exp_addr_q.size() == 0 && b_due_q.size() == 0));

    if (aw_seen == total_bursts && beats_seen == total_beats && w_len_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("the write went idle with bursts or beats missing");
    end
  end

endmodule

// File: filelist.f
common/axi_write_pkg.sv
design/sync_fifo.sv
burst_split/burst_split_fsm.sv
design/aw_issue.sv
design/wdata_beat_counter.sv
design/axi_write_master.sv
tb/axi_write_properties.sv
tb/tb_axi_write_master.sv

// File: run_sim.sh
#!/bin/sh
# build and run the AXI write master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi_write_master -Mdir obj_dir -o sim_axi_write_master \
  -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_axi_write_master
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
